// ==== list.f ====
+incdir+verilog
verilog/gemm_pkg.sv
verilog/tile_ctrl_if.sv
verilog/gemm_pe.sv
verilog/skew_buffer.sv
verilog/systolic_array.sv
verilog/acc_update.sv
verilog/gemm_sequencer.sv
verilog/gemm_top.sv
tests/tb_gemm_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_gemm_top \
  -o sim_gemm > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/sim_gemm > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
if [ $status -ne 0 ] || ! grep -q "TESTS PASSED" sim.log; then
  echo "simulation did not complete"
  exit 1
fi
exit 0

// ==== tests/gemm_trace.txt ====
// first word: case count. per case: header {inp_base,wgt_base,acc_base,rows},
// four weight rows, then per row: input word, initial acc row, expected acc row
4
// signed extremes and 32-bit wrap
10203002
00017f80 00000000 00000000 01010101
02070580 0 00000002_ffffff82_ffffc082_00004002
8000007f 00000000_00000000_7fffffff_00000010 ffffff80_ffffffff_80003e80_ffffc010
// zero weights, one row
40506001
00000000 00000000 00000000 00000000
7f80ff01 11111111_22222222_33333333_44444444 11111111_22222222_33333333_44444444
// eleven rows, more than fit in flight
8090a00b
00000001 00000100 00010000 ff000002
01000000 0 ffffffff_00000000_00000000_00000002
01010101 0 ffffffff_00000001_00000001_00000003
01020202 0 ffffffff_00000002_00000002_00000004
01030303 0 ffffffff_00000003_00000003_00000005
01040404 0 ffffffff_00000004_00000004_00000006
01050505 0 ffffffff_00000005_00000005_00000007
01060606 0 ffffffff_00000006_00000006_00000008
01070707 0 ffffffff_00000007_00000007_00000009
01080808 0 ffffffff_00000008_00000008_0000000a
01090909 0 ffffffff_00000009_00000009_0000000b
010a0a0a 0 ffffffff_0000000a_0000000a_0000000c
// all weights minus one
c0d0e003
ffffffff ffffffff ffffffff ffffffff
04030201 00000010_00000010_00000010_00000010 00000006_00000006_00000006_00000006
ffffffff 0 00000004_00000004_00000004_00000004
64646464 00000190_00000190_00000190_00000190 0

// ==== tests/tb_gemm_top.sv ====
`include "gemm_cfg.svh"

module tb_gemm_top import gemm_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int    CLK_PERIOD = 8;
  localparam int    TIMEOUT    = 2000;
  localparam string TRACE_FILE = "tests/gemm_trace.txt";

  logic clk = 1'b0;
  logic reset_n, start, busy, done;
  logic [`GEMM_INP_AW-1:0] inp_base, inp_rd_addr;
  logic [`GEMM_WGT_AW-1:0] wgt_base, wgt_rd_addr;
  logic [`GEMM_ACC_AW-1:0] acc_base, acc_rd_addr, acc_wr_addr, ld_addr;
  logic [`GEMM_ROWS_W-1:0] row_count;
  logic inp_rd_en, wgt_rd_en, acc_rd_en, acc_wr_en, ld_en;
  inp_vec_t inp_rd_data = '0;
  wgt_vec_t wgt_rd_data = '0;
  acc_vec_t acc_rd_data = '0;
  acc_vec_t acc_wr_data, ld_data;

  // memory models and the trace image
  logic [31:0]  inp_mem [256];
  logic [31:0]  wgt_mem [256];
  acc_vec_t     acc_mem [256];
  logic [127:0] exp_acc [256];
  logic [127:0] trace   [512];
  int           done_cnt = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  gemm_top gemm_top_i (.*);

  function automatic logic [127:0] acc_fill(input logic [7:0] a);
    return {24'hacc003, a, 24'hacc002, a, 24'hacc001, a, 24'hacc000, a};
  endfunction

  // ====================================================================
  // memory read ports with one cycle of latency
  // ====================================================================
  always @(posedge clk) begin
    if (inp_rd_en) inp_rd_data <= #1 inp_mem[inp_rd_addr];
    if (wgt_rd_en) wgt_rd_data <= #1 wgt_mem[wgt_rd_addr];
    if (acc_rd_en) acc_rd_data <= #1 acc_mem[acc_rd_addr];
  end

  // accumulator memory is filled in reset and then takes DUT writes or trace loads
  always @(posedge clk) begin
    if (!reset_n) begin
      for (int a = 0; a < 256; a++) acc_mem[a] <= acc_fill(8'(a));
    end else if (acc_wr_en) begin
      acc_mem[acc_wr_addr] <= acc_wr_data;
    end else if (ld_en) begin
      acc_mem[ld_addr] <= ld_data;
    end
  end

  always @(posedge clk) begin
    if (reset_n && done) done_cnt <= done_cnt + 1;
  end

  task automatic check_value(input string name, input logic [127:0] got, exp);
    if (got !== exp) begin
      $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "check failed");
    end
  endtask

  task automatic pulse_start(input logic [7:0] ib, wb, ab, rows);
    @(posedge clk);
    #1;
    {inp_base, wgt_base, acc_base, row_count} = {ib, wb, ab, rows};
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  // ====================================================================
  // one trace case loads, starts, retries start while busy, waits and compares
  // ====================================================================
  task automatic run_case(input int idx, inout int ptr);
    logic [31:0] hdr;
    logic [7:0]  ib, wb, ab, rows;
    int          cyc;
    hdr = trace[ptr][31:0];
    {ib, wb, ab, rows} = hdr;
    for (int k = 0; k < `GEMM_ARRAY_N; k++) wgt_mem[8'(wb + k)] = trace[ptr + 1 + k][31:0];
    ptr = ptr + 1 + `GEMM_ARRAY_N;
    for (int r = 0; r < int'(rows); r++) begin
      inp_mem[8'(ib + r)] = trace[ptr][31:0];
      exp_acc[8'(ab + r)] = trace[ptr + 2];
      @(posedge clk);
      #1;
      ld_en   = 1'b1;
      ld_addr = 8'(ab + r);
      ld_data = trace[ptr + 1];
      ptr = ptr + 3;
    end
    @(posedge clk);
    #1;
    ld_en = 1'b0;
    pulse_start(ib, wb, ab, rows);
    // a second start while busy must be ignored
    pulse_start(8'h00, 8'h00, 8'h00, 8'h01);
    @(negedge clk);
    check_value("busy", 128'(busy), 128'(1));
    cyc = 0;
    while (done !== 1'b1) begin
      @(negedge clk);
      cyc++;
      if (cyc > TIMEOUT) begin
        $display("timeout: done never came in case %0d", idx);
        $display("TESTS FAILED");
        $fatal(1, "timeout");
      end
    end
    @(negedge clk);
    check_value("busy", 128'(busy), 128'(0));
    check_value("done", 128'(done), 128'(0));
    check_value("done_cnt", 128'(done_cnt), 128'(idx + 1));
    for (int a = 0; a < 256; a++) begin
      check_value($sformatf("acc_mem[%0d]", a), acc_mem[a], exp_acc[a]);
    end
  endtask

  initial begin
    int ptr;
    int n_cases;
    {reset_n, start, ld_en} = 3'b000;
    {inp_base, wgt_base, acc_base, row_count, ld_addr} = '0;
    ld_data = '0;
    for (int a = 0; a < 256; a++) begin
      inp_mem[a] = {4{8'(a) ^ 8'h5a}};
      wgt_mem[a] = {4{8'(a) ^ 8'hc3}};
      exp_acc[a] = acc_fill(8'(a));
    end
    $readmemh(TRACE_FILE, trace);
    repeat (5) @(posedge clk);
    #1;
    reset_n = 1'b1;
    @(negedge clk);
    check_value("busy", 128'(busy), 128'(0));
    check_value("done", 128'(done), 128'(0));
    check_value("rd_en", 128'({inp_rd_en, wgt_rd_en, acc_rd_en}), 128'(0));
    check_value("acc_wr_en", 128'(acc_wr_en), 128'(0));
    n_cases = int'(trace[0][31:0]);
    ptr = 1;
    for (int c = 0; c < n_cases; c++) run_case(c, ptr);
    repeat (20) @(negedge clk);
    check_value("done_cnt", 128'(done_cnt), 128'(n_cases));
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== verilog/acc_update.sv ====
`include "gemm_cfg.svh"

module acc_update import gemm_pkg::*; (
  input  logic                    clk,
  input  logic                    reset_n,
  tile_ctrl_if.accum              ctrl,
  input  psum_vec_t               col_sums,
  input  acc_vec_t                acc_rd_data,
  output logic                    acc_wr_en,
  output logic [`GEMM_ACC_AW-1:0] acc_wr_addr,
  output acc_vec_t                acc_wr_data
);

  localparam int N = `GEMM_ARRAY_N;

  // issue info lined up with the read data
  logic                    rd_valid;
  logic [`GEMM_ACC_AW-1:0] rd_addr;
  acc_vec_t                sums_ext;

  // column sums widened to accumulator lanes
  always_comb begin
    for (int j = 0; j < N; j++) begin
      sums_ext[j] = acc_t'($signed(col_sums[j]));
    end
  end

  // ====================================================================
  // write strobe trails the issue by the read latency plus one register
  // ====================================================================
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rd_valid  <= 1'b0;
      acc_wr_en <= 1'b0;
    end else begin
      rd_valid  <= ctrl.acc_issue;
      acc_wr_en <= rd_valid;
    end
  end

  // read-modify-write data path with a 32-bit wrapping add
  always_ff @(posedge clk) begin
    rd_addr     <= ctrl.acc_addr;
    acc_wr_addr <= rd_addr;
    for (int j = 0; j < N; j++) begin
      acc_wr_data[j] <= acc_rd_data[j] + sums_ext[j];
    end
  end

  // back-to-back writes land on consecutive accumulator rows
  wr_rows_in_order: assert property (@(posedge clk) disable iff (!reset_n)
    (acc_wr_en && $past(acc_wr_en)) |-> (acc_wr_addr == $past(acc_wr_addr) + 1'b1));

endmodule

// ==== verilog/gemm_cfg.svh ====
`ifndef GEMM_CFG_SVH
`define GEMM_CFG_SVH

// array side length, also the lane count of every memory word
`define GEMM_ARRAY_N 4

// element widths
`define GEMM_INP_W 8
`define GEMM_WGT_W 8
`define GEMM_ACC_W 32

// product width plus growth over one column of adds
`define GEMM_PSUM_W (`GEMM_INP_W + `GEMM_WGT_W + $clog2(`GEMM_ARRAY_N))

// memory address widths
`define GEMM_INP_AW 8
`define GEMM_WGT_AW 8
`define GEMM_ACC_AW 8

// row count port
`define GEMM_ROWS_W 8

`endif

// ==== verilog/gemm_pe.sv ====
module gemm_pe import gemm_pkg::*; (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  wgt_shift,
  input  wgt_t  wgt_in,
  output wgt_t  wgt_out,
  input  inp_t  act_in,
  output inp_t  act_out,
  input  psum_t psum_in,
  output psum_t psum_out
);

  // stationary weight
  wgt_t wgt_q;

  assign wgt_out = wgt_q;

  // weight chain, one row per shift
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wgt_q <= '0;
    end else if (wgt_shift) begin
      wgt_q <= wgt_in;
    end
  end

  // operands are sign-extended to the psum width before the multiply
  always_ff @(posedge clk) begin
    act_out  <= act_in;
    psum_out <= psum_in + act_in * wgt_q;
  end

endmodule

// ==== verilog/gemm_pkg.sv ====
`include "gemm_cfg.svh"

package gemm_pkg;

  // ====================================================================
  // single lanes
  // ====================================================================

  // signed input element
  typedef logic signed [`GEMM_INP_W-1:0] inp_t;

  // signed weight element
  typedef logic signed [`GEMM_WGT_W-1:0] wgt_t;

  // accumulator element, wraps on overflow
  typedef logic signed [`GEMM_ACC_W-1:0] acc_t;

  // column partial sum inside the array
  typedef logic signed [`GEMM_PSUM_W-1:0] psum_t;

  // ====================================================================
  // full words, lane 0 in the low bits
  // ====================================================================

  // input memory word, element k feeds PE row k
  typedef inp_t [`GEMM_ARRAY_N-1:0] inp_vec_t;

  // weight memory word, element j belongs to column j
  typedef wgt_t [`GEMM_ARRAY_N-1:0] wgt_vec_t;

  // accumulator memory word
  typedef acc_t [`GEMM_ARRAY_N-1:0] acc_vec_t;

  // one set of column sums
  typedef psum_t [`GEMM_ARRAY_N-1:0] psum_vec_t;

endpackage

// ==== verilog/gemm_sequencer.sv ====
`include "gemm_cfg.svh"

module gemm_sequencer (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    start,
  input  logic [`GEMM_INP_AW-1:0] inp_base,
  input  logic [`GEMM_WGT_AW-1:0] wgt_base,
  input  logic [`GEMM_ACC_AW-1:0] acc_base,
  input  logic [`GEMM_ROWS_W-1:0] row_count,
  output logic                    busy,
  output logic                    done,
  output logic                    inp_rd_en,
  output logic [`GEMM_INP_AW-1:0] inp_rd_addr,
  output logic                    wgt_rd_en,
  output logic [`GEMM_WGT_AW-1:0] wgt_rd_addr,
  output logic                    acc_rd_en,
  output logic [`GEMM_ACC_AW-1:0] acc_rd_addr,
  tile_ctrl_if.ctrl               ctrl
);

  localparam int N       = `GEMM_ARRAY_N;
  localparam int LANE_CW = (N > 1) ? $clog2(N) : 1;
  localparam int INP_AW  = `GEMM_INP_AW;
  localparam int WGT_AW  = `GEMM_WGT_AW;

  // pipe bit 0 is one cycle after act_valid, i.e. two after the input read.
  // sums land 2N+1 after read data, so the acc read goes out 2N+1 after
  // the input read and the write follows two cycles later
  localparam int PIPE_LEN  = 2 * N + 2;
  localparam int ISSUE_TAP = 2 * N - 1;
  localparam int WRITE_TAP = 2 * N + 1;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WGT,
    S_STREAM,
    S_DRAIN
  } state_t;

  state_t                  state;
  logic [LANE_CW-1:0]      lane_cnt;
  logic [`GEMM_ROWS_W-1:0] row_cnt;
  logic [`GEMM_ROWS_W-1:0] rows_q;
  logic [`GEMM_ROWS_W-1:0] rows_left;
  logic [`GEMM_ACC_AW-1:0] acc_cnt;
  logic [`GEMM_INP_AW-1:0] inp_base_q;
  logic [`GEMM_WGT_AW-1:0] wgt_base_q;
  logic [`GEMM_ACC_AW-1:0] acc_base_q;
  logic [PIPE_LEN-1:0]     issue_pipe;
  logic                    wr_strobe;

  assign busy      = (state != S_IDLE);
  assign wgt_rd_en = (state == S_WGT);
  assign inp_rd_en = (state == S_STREAM);
  assign acc_rd_en = issue_pipe[ISSUE_TAP];
  assign wr_strobe = issue_pipe[WRITE_TAP];

  // lane counter runs down, so the bottom PE row's weights go in first
  assign wgt_rd_addr = wgt_base_q + WGT_AW'(lane_cnt);
  assign inp_rd_addr = inp_base_q + INP_AW'(row_cnt);
  assign acc_rd_addr = acc_base_q + acc_cnt;

  assign ctrl.acc_issue = acc_rd_en;
  assign ctrl.acc_addr  = acc_rd_addr;

  // ====================================================================
  // run parameters, captured with an accepted start
  // ====================================================================
  always_ff @(posedge clk) begin
    if (state == S_IDLE && start) begin
      inp_base_q <= inp_base;
      wgt_base_q <= wgt_base;
      acc_base_q <= acc_base;
      rows_q     <= row_count;
    end
  end

  // ====================================================================
  // main FSM and row tracking
  // ====================================================================
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state          <= S_IDLE;
      done           <= 1'b0;
      lane_cnt       <= '0;
      row_cnt        <= '0;
      rows_left      <= '0;
      acc_cnt        <= '0;
      issue_pipe     <= '0;
      ctrl.wgt_shift <= 1'b0;
      ctrl.act_valid <= 1'b0;
    end else begin
      done           <= 1'b0;
      ctrl.wgt_shift <= wgt_rd_en;
      ctrl.act_valid <= inp_rd_en;
      issue_pipe     <= {issue_pipe[PIPE_LEN-2:0], ctrl.act_valid};
      if (acc_rd_en) begin
        acc_cnt <= acc_cnt + 1'b1;
      end
      // one row leaves the pipeline per write
      if (wr_strobe) begin
        rows_left <= rows_left - 1'b1;
      end
      case (state)
        S_IDLE: begin
          if (start) begin
            state     <= S_WGT;
            lane_cnt  <= LANE_CW'(N - 1);
            row_cnt   <= '0;
            rows_left <= row_count;
            acc_cnt   <= '0;
          end
        end
        S_WGT: begin
          lane_cnt <= lane_cnt - 1'b1;
          if (lane_cnt == '0) begin
            state <= S_STREAM;
          end
        end
        S_STREAM: begin
          row_cnt <= row_cnt + 1'b1;
          if (row_cnt == rows_q - 1'b1) begin
            state <= S_DRAIN;
          end
        end
        default: begin
          // last write goes out this cycle
          if (wr_strobe && rows_left == 1) begin
            state <= S_IDLE;
            done  <= 1'b1;
          end
        end
      endcase
    end
  end

  // zero rows would leave the drain phase waiting on a write that never comes
  start_rows_nonzero: assert property (@(posedge clk) disable iff (!reset_n)
    (start && state == S_IDLE) |-> (row_count != '0));

endmodule

// ==== verilog/gemm_top.sv ====
`include "gemm_cfg.svh"

module gemm_top import gemm_pkg::*; (
  input  logic                    clk,
  input  logic                    reset_n,

  // run control
  input  logic                    start,
  input  logic [`GEMM_INP_AW-1:0] inp_base,
  input  logic [`GEMM_WGT_AW-1:0] wgt_base,
  input  logic [`GEMM_ACC_AW-1:0] acc_base,
  input  logic [`GEMM_ROWS_W-1:0] row_count,
  output logic                    busy,
  output logic                    done,

  // input memory read port
  output logic                    inp_rd_en,
  output logic [`GEMM_INP_AW-1:0] inp_rd_addr,
  input  inp_vec_t                inp_rd_data,

  // weight memory read port
  output logic                    wgt_rd_en,
  output logic [`GEMM_WGT_AW-1:0] wgt_rd_addr,
  input  wgt_vec_t                wgt_rd_data,

  // accumulator memory read and write ports
  output logic                    acc_rd_en,
  output logic [`GEMM_ACC_AW-1:0] acc_rd_addr,
  input  acc_vec_t                acc_rd_data,
  output logic                    acc_wr_en,
  output logic [`GEMM_ACC_AW-1:0] acc_wr_addr,
  output acc_vec_t                acc_wr_data
);

  tile_ctrl_if ctrl_if ();

  inp_vec_t  act_skewed;
  psum_vec_t sums_skewed;
  psum_vec_t sums_aligned;

  // ====================================================================
  // control
  // ====================================================================
  gemm_sequencer seq_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .start       (start),
    .inp_base    (inp_base),
    .wgt_base    (wgt_base),
    .acc_base    (acc_base),
    .row_count   (row_count),
    .busy        (busy),
    .done        (done),
    .inp_rd_en   (inp_rd_en),
    .inp_rd_addr (inp_rd_addr),
    .wgt_rd_en   (wgt_rd_en),
    .wgt_rd_addr (wgt_rd_addr),
    .acc_rd_en   (acc_rd_en),
    .acc_rd_addr (acc_rd_addr),
    .ctrl        (ctrl_if)
  );

  // ====================================================================
  // datapath
  // ====================================================================
  skew_buffer #(.LANE_W(`GEMM_INP_W), .REVERSE(1'b0)) inp_skew (
    .clk      (clk),
    .data_in  (inp_rd_data),
    .data_out (act_skewed)
  );

  systolic_array array_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .ctrl     (ctrl_if),
    .wgt_in   (wgt_rd_data),
    .act_in   (act_skewed),
    .col_sums (sums_skewed)
  );

  // undo the column skew so all sums of a row line up
  skew_buffer #(.LANE_W(`GEMM_PSUM_W), .REVERSE(1'b1)) sum_deskew (
    .clk      (clk),
    .data_in  (sums_skewed),
    .data_out (sums_aligned)
  );

  acc_update acc_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .ctrl        (ctrl_if),
    .col_sums    (sums_aligned),
    .acc_rd_data (acc_rd_data),
    .acc_wr_en   (acc_wr_en),
    .acc_wr_addr (acc_wr_addr),
    .acc_wr_data (acc_wr_data)
  );

endmodule

// ==== verilog/skew_buffer.sv ====
`include "gemm_cfg.svh"

module skew_buffer #(
  parameter int LANE_W  = 8,
  parameter bit REVERSE = 1'b0
) (
  input  logic                                 clk,
  input  logic [`GEMM_ARRAY_N-1:0][LANE_W-1:0] data_in,
  output logic [`GEMM_ARRAY_N-1:0][LANE_W-1:0] data_out
);

  localparam int N = `GEMM_ARRAY_N;

  // ====================================================================
  // triangle of shift registers
  // ====================================================================
  // every lane gets at least one register stage, so lane i sees i+1
  // cycles, or N-i when reversed. relative skew between lanes is
  // what the array needs
  for (genvar i = 0; i < N; i++) begin : g_lane
    localparam int DEPTH = REVERSE ? (N - i) : (i + 1);

    logic [LANE_W-1:0] taps [DEPTH];

    always_ff @(posedge clk) begin
      taps[0] <= data_in[i];
      for (int s = 1; s < DEPTH; s++) begin
        taps[s] <= taps[s-1];
      end
    end

    assign data_out[i] = taps[DEPTH-1];
  end

endmodule

// ==== verilog/systolic_array.sv ====
`include "gemm_cfg.svh"

module systolic_array import gemm_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,
  tile_ctrl_if.array ctrl,
  input  wgt_vec_t   wgt_in,
  input  inp_vec_t   act_in,
  output psum_vec_t  col_sums
);

  localparam int N = `GEMM_ARRAY_N;

  // ====================================================================
  // links between PEs
  // ====================================================================
  // weights and psums travel down the columns, activations across rows
  wgt_t  wgt_link  [N+1][N];
  inp_t  act_link  [N][N+1];
  psum_t psum_link [N+1][N];

  // column edges: top of the weight chain, zero psum in, sums out
  for (genvar j = 0; j < N; j++) begin : g_edge
    assign wgt_link[0][j]  = wgt_in[j];
    assign psum_link[0][j] = '0;
    assign col_sums[j]     = psum_link[N][j];
  end

  // ====================================================================
  // PE grid, row k holds weight row k
  // ====================================================================
  for (genvar k = 0; k < N; k++) begin : g_row
    assign act_link[k][0] = act_in[k];

    for (genvar j = 0; j < N; j++) begin : g_col
      gemm_pe pe_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .wgt_shift (ctrl.wgt_shift),
        .wgt_in    (wgt_link[k][j]),
        .wgt_out   (wgt_link[k+1][j]),
        .act_in    (act_link[k][j]),
        .act_out   (act_link[k][j+1]),
        .psum_in   (psum_link[k][j]),
        .psum_out  (psum_link[k+1][j])
      );
    end
  end

endmodule

// ==== verilog/tile_ctrl_if.sv ====
`include "gemm_cfg.svh"

interface tile_ctrl_if;

  // weights move one PE row down
  logic                    wgt_shift;
  // input read data of this cycle is a real row
  logic                    act_valid;
  // accumulator read issued this cycle, and its address
  logic                    acc_issue;
  logic [`GEMM_ACC_AW-1:0] acc_addr;

  modport ctrl (output wgt_shift, output act_valid, output acc_issue, output acc_addr);

  modport array (input wgt_shift);

  modport accum (input acc_issue, input acc_addr);

endinterface
